// ==== tb/router_stats_golden.txt ====
# op W: addr data | R: addr exp_data exp_err | C: port pkt byte err (all hex)
# op O: port_mask pulses | E: exp_port_enable | I: idle_cycles
E 7ff
R 1 7ff 0
R 2 0 0
R 3 0 0
R 4 0 0
W 0 5a5
E 5a5
I 1
R 1 5a5 0
W 1 123
W 4 abc
R 1 5a5 0
R 4 0 0
C 0 10 400 1
C 5 30 c00 3
W 2 1
W 3 1
R 4 400 0
W 3 500
R 4 0 0
C 0 11 401 5
W 2 21
R 4 30 0
W 3 2
R 4 1 0
W 2 20
W 2 21
R 4 5 0
O 4 3
W 2 4
W 3 203
R 4 3 0
W 2 0
W 2 4
R 4 0 0
W 3 b00
R 4 0 0
W 3 4
R 4 0 0
R 5 0 1
R 7 0 1

// ==== tb.f ====
hw/router_stats_pkg.sv
hw/router_regs_pkg.sv
hw/stats_snap_ifc.sv
hw/port_stats_slice.sv
hw/stats_read_sel.sv
hw/stats_reg_ctrl.sv
hw/router_stats_top.sv
tb/router_stats_checker.sv
tb/router_stats_tb.sv

// ==== tb/router_stats_tb.sv ====
// Router statistics testbench
// Replays the golden operation list against the register block and checks responses

`timescale 1ns/1ps

module router_stats_tb;

    localparam int NUM_PORTS = 11;
    localparam int CNT_WIDTH = 32;
    localparam string GOLDEN_FILE = "tb/router_stats_golden.txt";

    logic                               core_clk_ifc;
    logic                               peripheral_sresetn_core;
    logic                               reg_write;
    logic                               reg_read;
    logic [2:0]                         reg_addr;
    logic [31:0]                        reg_wdata;
    logic [31:0]                        reg_rdata;
    logic                               reg_rvalid;
    logic                               reg_rerr;
    logic [NUM_PORTS-1:0][CNT_WIDTH-1:0] pkt_cnt;
    logic [NUM_PORTS-1:0][CNT_WIDTH-1:0] byte_cnt;
    logic [NUM_PORTS-1:0][CNT_WIDTH-1:0] err_cnt;
    logic [NUM_PORTS-1:0]               buf_overflow;
    logic [NUM_PORTS-1:0]               port_enable;

    int cycle_count = 0;
    int cycle_limit = 1000;
    int assert_fails;

    router_stats_top #(
        .NUM_PORTS ( NUM_PORTS ),
        .CNT_WIDTH ( CNT_WIDTH )
    ) router_stats_top_i (.*);

    assign assert_fails = router_stats_top_i.stats_reg_ctrl_i.router_stats_checker_i.fail_count;

    initial core_clk_ifc = 1'b0;
    always #10 core_clk_ifc = ~core_clk_ifc;

    ////////////////////
    // Watchdog

    always @(posedge core_clk_ifc) begin
        if (assert_fails != 0) begin
            $display("The bound checker reported %0d assertion failures", assert_fails);
            $display("Testbench failed");
            $fatal(1, "assertion failure");
        end else if (cycle_count >= cycle_limit) begin
            $display("Timeout: golden operations did not finish in %0d cycles", cycle_limit);
            $display("Testbench failed");
            $fatal(1, "run stopped by timeout");
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    ////////////////////
    // Helpers

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s actual 0x%08h expected 0x%08h", name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic require_fields(input string op, input int got, input int want);
        if (got != want) begin
            $display("Golden line for operation %s has %0d of %0d fields", op, got, want);
            $display("Testbench failed");
            $fatal(1, "bad golden file");
        end
    endtask

    // Inputs always move 2 ns past the rising edge
    task automatic next_cycle(input int n);
        repeat (n) begin
            @(posedge core_clk_ifc);
            #2;
        end
    endtask

    task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
        reg_write = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        next_cycle(1);
        reg_write = 1'b0;
        // Let select and snapshot pipelines settle
        next_cycle(4);
    endtask

    task automatic read_reg(input logic [2:0] addr, input logic [31:0] exp_data,
                            input logic exp_err);
        int wait_cycles;
        reg_read = 1'b1;
        reg_addr = addr;
        next_cycle(1);
        reg_read    = 1'b0;
        wait_cycles = 0;
        while (reg_rvalid !== 1'b1) begin
            if (wait_cycles == 8) begin
                $display("Read of address %0d got no valid response", addr);
                $display("Testbench failed");
                $fatal(1, "read response missing");
            end else begin
                next_cycle(1);
                wait_cycles++;
            end
        end
        check_value("reg_rdata", reg_rdata, exp_data);
        check_value("reg_rerr", reg_rerr, exp_err);
    endtask

    task automatic pulse_overflow(input logic [NUM_PORTS-1:0] mask, input int pulses);
        repeat (pulses) begin
            buf_overflow = mask;
            next_cycle(3);
            buf_overflow = '0;
            next_cycle(3);
        end
        next_cycle(4);
    endtask

    ////////////////////
    // Golden file replay

    initial begin
        int fd;
        int n;
        int line_count;
        string op;
        string line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;

        peripheral_sresetn_core = 1'b0;
        reg_write    = 1'b0;
        reg_read     = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        pkt_cnt      = '0;
        byte_cnt     = '0;
        err_cnt      = '0;
        buf_overflow = '0;

        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the golden file %s", GOLDEN_FILE);
            $display("Testbench failed");
            $fatal(1, "missing stimulus");
        end
        line_count = 0;
        while ($fgets(line, fd) != 0) begin
            line_count++;
        end
        $fclose(fd);
        cycle_limit = 40 * line_count + 100;
        fd = $fopen(GOLDEN_FILE, "r");

        next_cycle(5);
        peripheral_sresetn_core = 1'b1;

        while ($fscanf(fd, "%s", op) == 1) begin
            if (op == "#") begin
                n = $fgets(line, fd);
            end else if (op == "W") begin
                n = $fscanf(fd, "%h %h", a, b);
                require_fields(op, n, 2);
                write_reg(a[2:0], b);
            end else if (op == "R") begin
                n = $fscanf(fd, "%h %h %h", a, b, c);
                require_fields(op, n, 3);
                read_reg(a[2:0], b, c[0]);
            end else if (op == "C") begin
                n = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                require_fields(op, n, 4);
                pkt_cnt[a]  = b;
                byte_cnt[a] = c;
                err_cnt[a]  = d;
            end else if (op == "O") begin
                n = $fscanf(fd, "%h %h", a, b);
                require_fields(op, n, 2);
                pulse_overflow(a[NUM_PORTS-1:0], b);
            end else if (op == "E") begin
                n = $fscanf(fd, "%h", a);
                require_fields(op, n, 1);
                check_value("port_enable", port_enable, a);
            end else if (op == "I") begin
                n = $fscanf(fd, "%h", a);
                require_fields(op, n, 1);
                next_cycle(a);
            end else begin
                $display("Unknown operation %s in the golden file", op);
                $display("Testbench failed");
                $fatal(1, "bad golden file");
            end
        end
        $fclose(fd);

        next_cycle(2);
        if (assert_fails != 0) begin
            $display("The bound checker reported %0d assertion failures", assert_fails);
            $display("Testbench failed");
            $fatal(1, "assertion failure");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// ==== tb/router_stats_checker.sv ====
// Statistics control checker
// Sample pulse width, read response timing and enable state after reset

`timescale 1ns/1ps

module router_stats_checker #(
    parameter int NUM_PORTS = 11
) (
    input logic                 core_clk_ifc,
    input logic                 peripheral_sresetn_core,
    input logic                 reg_write,
    input logic                 reg_read,
    input logic                 reg_rvalid,
    input logic [NUM_PORTS-1:0] port_enable,
    input logic [NUM_PORTS-1:0] sample_pulse
);
    int fail_count = 0;

    // Pulses last one cycle only
    pulse_width: assert property (@(posedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
        (sample_pulse & $past(sample_pulse)) == '0)
        else begin
            $error("sample_pulse stayed high for two cycles");
            fail_count++;
        end

    // Write wins a collision, so only a lone read gets a response
    read_timing: assert property (@(posedge core_clk_ifc) disable iff (!peripheral_sresetn_core)
        reg_rvalid == $past(reg_read && !reg_write))
        else begin
            $error("reg_rvalid did not follow reg_read by one cycle");
            fail_count++;
        end

    enable_reset: assert property (@(posedge core_clk_ifc)
        $rose(peripheral_sresetn_core) |-> (&port_enable))
        else begin
            $error("port_enable not all ones after reset");
            fail_count++;
        end

endmodule

bind stats_reg_ctrl router_stats_checker #(
    .NUM_PORTS ( NUM_PORTS )
) router_stats_checker_i (
    .core_clk_ifc            ( core_clk_ifc            ),
    .peripheral_sresetn_core ( peripheral_sresetn_core ),
    .reg_write               ( reg_write               ),
    .reg_read                ( reg_read                ),
    .reg_rvalid              ( reg_rvalid              ),
    .port_enable             ( port_enable             ),
    .sample_pulse            ( sample_pulse            )
);

// ==== hw/router_stats_top.sv ====
// Router statistics and port-control register block
// Register port, per-port statistics slices and snapshot read-back

`timescale 1ns/1ps

module router_stats_top #(
    parameter int NUM_PORTS = 11,
    parameter int CNT_WIDTH = 32
) (
    input  logic                                        core_clk_ifc,
    input  logic                                        peripheral_sresetn_core,
    input  logic                                        reg_write,
    input  logic                                        reg_read,
    input  logic [$bits(router_regs_pkg::reg_addr_e)-1:0] reg_addr,
    input  logic [router_regs_pkg::REG_W-1:0]           reg_wdata,
    output logic [router_regs_pkg::REG_W-1:0]           reg_rdata,
    output logic                                        reg_rvalid,
    output logic                                        reg_rerr,
    input  logic [NUM_PORTS-1:0][CNT_WIDTH-1:0]         pkt_cnt,
    input  logic [NUM_PORTS-1:0][CNT_WIDTH-1:0]         byte_cnt,
    input  logic [NUM_PORTS-1:0][CNT_WIDTH-1:0]         err_cnt,
    input  logic [NUM_PORTS-1:0]                        buf_overflow,
    output logic [NUM_PORTS-1:0]                        port_enable
);
    logic [NUM_PORTS-1:0]                       sample_pulse;
    logic [2*router_stats_pkg::SEL_FIELD_W-1:0] read_sel;
    logic [CNT_WIDTH-1:0]                       read_data;

    if (NUM_PORTS < 1 || NUM_PORTS > 32 || CNT_WIDTH < 1 || CNT_WIDTH > 32) begin : gen_bad_param
        $error("router_stats_top: NUM_PORTS and CNT_WIDTH must be 1 to 32");
    end

    stats_snap_ifc #(
        .NUM_PORTS ( NUM_PORTS ),
        .CNT_WIDTH ( CNT_WIDTH )
    ) snap_ifc ();

    ////////////////////
    // Register control

    stats_reg_ctrl #(
        .NUM_PORTS ( NUM_PORTS ),
        .CNT_WIDTH ( CNT_WIDTH )
    ) stats_reg_ctrl_i (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .reg_write               ( reg_write               ),
        .reg_read                ( reg_read                ),
        .reg_addr                ( reg_addr                ),
        .reg_wdata               ( reg_wdata               ),
        .reg_rdata               ( reg_rdata               ),
        .reg_rvalid              ( reg_rvalid              ),
        .reg_rerr                ( reg_rerr                ),
        .port_enable             ( port_enable             ),
        .sample_pulse            ( sample_pulse            ),
        .read_sel                ( read_sel                ),
        .read_data               ( read_data               )
    );

    ////////////////////
    // One slice per port

    for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_slice
        port_stats_slice #(
            .CNT_WIDTH  ( CNT_WIDTH ),
            .port_index ( p         )
        ) port_stats_slice_i (
            .core_clk_ifc            ( core_clk_ifc            ),
            .peripheral_sresetn_core ( peripheral_sresetn_core ),
            .sample                  ( sample_pulse[p]         ),
            .overflow                ( buf_overflow[p]         ),
            .pkt_cnt                 ( pkt_cnt[p]              ),
            .byte_cnt                ( byte_cnt[p]             ),
            .err_cnt                 ( err_cnt[p]              ),
            .snap                    ( snap_ifc                )
        );
    end

    stats_read_sel #(
        .NUM_PORTS ( NUM_PORTS ),
        .CNT_WIDTH ( CNT_WIDTH )
    ) stats_read_sel_i (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .read_sel                ( read_sel                ),
        .snap                    ( snap_ifc                ),
        .read_data               ( read_data               )
    );

endmodule

// ==== hw/stats_reg_ctrl.sv ====
// Statistics control registers
// Write decode, port enables, sample pulse generation and register read-back

`timescale 1ns/1ps

module stats_reg_ctrl #(
    parameter int NUM_PORTS = 11,
    parameter int CNT_WIDTH = 32
) (
    input  logic                                        core_clk_ifc,
    input  logic                                        peripheral_sresetn_core,
    input  logic                                        reg_write,
    input  logic                                        reg_read,
    input  logic [$bits(router_regs_pkg::reg_addr_e)-1:0] reg_addr,
    input  logic [router_regs_pkg::REG_W-1:0]           reg_wdata,
    output logic [router_regs_pkg::REG_W-1:0]           reg_rdata,
    output logic                                        reg_rvalid,
    output logic                                        reg_rerr,
    output logic [NUM_PORTS-1:0]                        port_enable,
    output logic [NUM_PORTS-1:0]                        sample_pulse,
    output logic [2*router_stats_pkg::SEL_FIELD_W-1:0]  read_sel,
    input  logic [CNT_WIDTH-1:0]                        read_data
);
    localparam int REG_W = router_regs_pkg::REG_W;
    localparam int SEL_W = 2 * router_stats_pkg::SEL_FIELD_W;
    localparam logic [REG_W-1:0] ENABLE_RST_WORD = router_regs_pkg::enable_rst(NUM_PORTS);
    localparam logic [REG_W-1:0] SAMPLE_RST_WORD = router_regs_pkg::SAMPLE_CON_RST;
    localparam logic [REG_W-1:0] SEL_RST_WORD    = router_regs_pkg::READ_SEL_RST;

    logic [NUM_PORTS-1:0] enable_con;
    logic [NUM_PORTS-1:0] enable_stat;
    logic [NUM_PORTS-1:0] sample_con;
    logic [NUM_PORTS-1:0] sample_con_d;
    logic [REG_W-1:0]     rd_word;
    logic                 rd_err;
    logic                 rd_accept;

    ////////////////////
    // Control registers

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            enable_con <= ENABLE_RST_WORD[NUM_PORTS-1:0];
            sample_con <= SAMPLE_RST_WORD[NUM_PORTS-1:0];
            read_sel   <= SEL_RST_WORD[SEL_W-1:0];
        end else if (reg_write) begin
            // Read-only and unmapped addresses fall through
            case (router_regs_pkg::reg_addr_e'(reg_addr))
                router_regs_pkg::ADDR_PORT_ENABLE_CON:  enable_con <= reg_wdata[NUM_PORTS-1:0];
                router_regs_pkg::ADDR_CNTRS_SAMPLE_CON: sample_con <= reg_wdata[NUM_PORTS-1:0];
                router_regs_pkg::ADDR_CNTRS_READ_SEL:   read_sel   <= reg_wdata[SEL_W-1:0];
                default: ;
            endcase
        end
    end

    assign port_enable = enable_con;

    // Status copy and sample pulses lag the control registers by one cycle
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            enable_stat  <= ENABLE_RST_WORD[NUM_PORTS-1:0];
            sample_con_d <= SAMPLE_RST_WORD[NUM_PORTS-1:0];
            sample_pulse <= '0;
        end else begin
            enable_stat  <= enable_con;
            sample_con_d <= sample_con;
            sample_pulse <= sample_con & ~sample_con_d;
        end
    end

    ////////////////////
    // Read-back

    always_comb begin
        rd_word = '0;
        rd_err  = (reg_addr >= router_regs_pkg::NUM_REGS);
        case (router_regs_pkg::reg_addr_e'(reg_addr))
            router_regs_pkg::ADDR_PORT_ENABLE_CON:  rd_word = REG_W'(enable_con);
            router_regs_pkg::ADDR_PORT_ENABLE_STAT: rd_word = REG_W'(enable_stat);
            router_regs_pkg::ADDR_CNTRS_SAMPLE_CON: rd_word = REG_W'(sample_con);
            router_regs_pkg::ADDR_CNTRS_READ_SEL:   rd_word = REG_W'(read_sel);
            router_regs_pkg::ADDR_CNTRS_READ_DATA:  rd_word = REG_W'(read_data);
            default: rd_word = '0;
        endcase
    end

    // A write in the same cycle cancels the read
    assign rd_accept = reg_read & ~reg_write;

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            reg_rvalid <= 1'b0;
            reg_rerr   <= 1'b0;
        end else begin
            reg_rvalid <= rd_accept;
            reg_rerr   <= rd_accept & rd_err;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (rd_accept) begin
            reg_rdata <= rd_word;
        end
    end

endmodule

// ==== hw/stats_read_sel.sv ====
// Snapshot read selector
// Registers the range-checked select, then the chosen snapshot word

`timescale 1ns/1ps

module stats_read_sel #(
    parameter int NUM_PORTS = 11,
    parameter int CNT_WIDTH = 32
) (
    input  logic                                       core_clk_ifc,
    input  logic                                       peripheral_sresetn_core,
    input  logic [2*router_stats_pkg::SEL_FIELD_W-1:0] read_sel,
    stats_snap_ifc.reader                              snap,
    output logic [CNT_WIDTH-1:0]                       read_data
);
    localparam int FIELD_W = router_stats_pkg::SEL_FIELD_W;
    localparam int PORT_W  = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    logic [FIELD_W-1:0]         port_field;
    logic [FIELD_W-1:0]         cnt_field;
    logic                       sel_ok_q;
    logic [PORT_W-1:0]          port_q;
    router_stats_pkg::cnt_idx_e cnt_q;

    assign port_field = read_sel[router_regs_pkg::SEL_PORT_LSB +: FIELD_W];
    assign cnt_field  = read_sel[router_regs_pkg::SEL_CNT_LSB +: FIELD_W];

    // Select stage
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            sel_ok_q <= 1'b0;
        end else begin
            sel_ok_q <= (port_field < NUM_PORTS) &&
                        (cnt_field < router_stats_pkg::CNTS_PER_PORT);
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        port_q <= port_field[PORT_W-1:0];
        cnt_q  <= router_stats_pkg::cnt_idx_e'(cnt_field[1:0]);
    end

    // Out-of-range selects read as zero
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            read_data <= '0;
        end else begin
            read_data <= sel_ok_q ? snap.words[port_q][cnt_q] : '0;
        end
    end

endmodule

// ==== hw/port_stats_slice.sv ====
// Per-port statistics slice
// Counts overflow rising edges and snapshots the port counters on sample

`timescale 1ns/1ps

module port_stats_slice #(
    parameter int CNT_WIDTH  = 32,
    parameter int port_index = 0
) (
    input  logic                 core_clk_ifc,
    input  logic                 peripheral_sresetn_core,
    input  logic                 sample,
    input  logic                 overflow,
    input  logic [CNT_WIDTH-1:0] pkt_cnt,
    input  logic [CNT_WIDTH-1:0] byte_cnt,
    input  logic [CNT_WIDTH-1:0] err_cnt,
    stats_snap_ifc.slice         snap
);
    logic                 ovf_d;
    logic                 ovf_rise;
    logic [CNT_WIDTH-1:0] ovf_cnt;
    logic [CNT_WIDTH-1:0] snap_q [router_stats_pkg::CNTS_PER_PORT];

    ////////////////////
    // Overflow events

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            ovf_d    <= 1'b0;
            ovf_rise <= 1'b0;
        end else begin
            ovf_d    <= overflow;
            ovf_rise <= overflow & ~ovf_d;
        end
    end

    // Wraps at the counter width; an edge seen during sample starts the next count
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            ovf_cnt <= '0;
        end else if (sample) begin
            ovf_cnt <= ovf_rise ? CNT_WIDTH'(1) : '0;
        end else if (ovf_rise) begin
            ovf_cnt <= ovf_cnt + 1'b1;
        end
    end

    ////////////////////
    // Snapshot

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            snap_q <= '{default: '0};
        end else if (sample) begin
            snap_q[router_stats_pkg::CNT_PKT]  <= pkt_cnt;
            snap_q[router_stats_pkg::CNT_BYTE] <= byte_cnt;
            snap_q[router_stats_pkg::CNT_ERR]  <= err_cnt;
            snap_q[router_stats_pkg::CNT_OVF]  <= ovf_cnt;
        end
    end

    assign snap.pkt_snap[port_index]  = snap_q[router_stats_pkg::CNT_PKT];
    assign snap.byte_snap[port_index] = snap_q[router_stats_pkg::CNT_BYTE];
    assign snap.err_snap[port_index]  = snap_q[router_stats_pkg::CNT_ERR];
    assign snap.ovf_snap[port_index]  = snap_q[router_stats_pkg::CNT_OVF];

endmodule

// ==== hw/stats_snap_ifc.sv ====
// Port snapshot bundle between the statistics slices and the read selector

`timescale 1ns/1ps

interface stats_snap_ifc #(
    parameter int NUM_PORTS = 11,
    parameter int CNT_WIDTH = 32
);
    logic [CNT_WIDTH-1:0] pkt_snap  [NUM_PORTS];
    logic [CNT_WIDTH-1:0] byte_snap [NUM_PORTS];
    logic [CNT_WIDTH-1:0] err_snap  [NUM_PORTS];
    logic [CNT_WIDTH-1:0] ovf_snap  [NUM_PORTS];

    // Word view indexed the same way as the READ_SEL counter field
    logic [CNT_WIDTH-1:0] words [NUM_PORTS][router_stats_pkg::CNTS_PER_PORT];

    for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_words
        assign words[p][router_stats_pkg::CNT_PKT]  = pkt_snap[p];
        assign words[p][router_stats_pkg::CNT_BYTE] = byte_snap[p];
        assign words[p][router_stats_pkg::CNT_ERR]  = err_snap[p];
        assign words[p][router_stats_pkg::CNT_OVF]  = ovf_snap[p];
    end

    modport slice (output pkt_snap, byte_snap, err_snap, ovf_snap);
    modport reader (input words);
endinterface

// ==== hw/router_regs_pkg.sv ====
// Router statistics register map
// Word addresses, select field positions and reset values

package router_regs_pkg;

    localparam int REG_W = 32;

    typedef enum logic [2:0] {
        ADDR_PORT_ENABLE_CON  = 3'd0,
        ADDR_PORT_ENABLE_STAT = 3'd1,
        ADDR_CNTRS_SAMPLE_CON = 3'd2,
        ADDR_CNTRS_READ_SEL   = 3'd3,
        ADDR_CNTRS_READ_DATA  = 3'd4
    } reg_addr_e;

    localparam int NUM_REGS = 5;

    // Port field in 15:8 and counter field in 7:0 of READ_SEL
    localparam int SEL_PORT_LSB = 8;
    localparam int SEL_CNT_LSB  = 0;

    localparam logic [REG_W-1:0] SAMPLE_CON_RST = '0;
    localparam logic [REG_W-1:0] READ_SEL_RST   = '0;

    // All ports enabled out of reset
    function automatic logic [REG_W-1:0] enable_rst(input int num_ports);
        enable_rst = REG_W'((64'd1 << num_ports) - 64'd1);
    endfunction

endpackage

// ==== hw/router_stats_pkg.sv ====
// Router statistics path definitions
// Snapshot word count, word indices and select field width

package router_stats_pkg;

    // Snapshot words held per port
    localparam int CNTS_PER_PORT = 4;

    // Width of each READ_SEL subfield
    localparam int SEL_FIELD_W = 8;

    // Order of the snapshot words inside one port
    typedef enum logic [1:0] {
        CNT_PKT  = 2'd0,
        CNT_BYTE = 2'd1,
        CNT_ERR  = 2'd2,
        CNT_OVF  = 2'd3
    } cnt_idx_e;

endpackage
